//--- datapath.f
src/datapathPkg.sv
src/registerSelect.sv
src/generalRegister.sv
src/busMux.sv
src/specialRegisters.sv
src/alu.sv
src/datapath.sv
tb/datapathTb.sv

//--- tb/datapathTb.sv
`timescale 1ns/1ps

module datapathTb;

    localparam int numRegisters = 16;
    localparam time clkPeriod = 20ns;
    localparam int checkNone = 0;
    localparam int checkBus = 1;
    localparam int checkMar = 2;

    // One bit per control strobe in a table row.
    localparam logic [21:0] sGra = 22'd1 << 0;
    localparam logic [21:0] sGrb = 22'd1 << 1;
    localparam logic [21:0] sGrc = 22'd1 << 2;
    localparam logic [21:0] sRIn = 22'd1 << 3;
    localparam logic [21:0] sROut = 22'd1 << 4;
    localparam logic [21:0] sBaOut = 22'd1 << 5;
    localparam logic [21:0] sPcIn = 22'd1 << 6;
    localparam logic [21:0] sPcOut = 22'd1 << 7;
    localparam logic [21:0] sIrIn = 22'd1 << 8;
    localparam logic [21:0] sHiIn = 22'd1 << 9;
    localparam logic [21:0] sHiOut = 22'd1 << 10;
    localparam logic [21:0] sLoIn = 22'd1 << 11;
    localparam logic [21:0] sLoOut = 22'd1 << 12;
    localparam logic [21:0] sMarIn = 22'd1 << 13;
    localparam logic [21:0] sMdrIn = 22'd1 << 14;
    localparam logic [21:0] sMdrOut = 22'd1 << 15;
    localparam logic [21:0] sRead = 22'd1 << 16;
    localparam logic [21:0] sYIn = 22'd1 << 17;
    localparam logic [21:0] sZIn = 22'd1 << 18;
    localparam logic [21:0] sZHighOut = 22'd1 << 19;
    localparam logic [21:0] sZLowOut = 22'd1 << 20;
    localparam logic [21:0] sIncPc = 22'd1 << 21;

    logic clk;
    logic reset;
    logic gra, grb, grc, rIn, rOut, baOut, pcIn, pcOut, irIn, hiIn, hiOut;
    logic loIn, loOut, marIn, mdrIn, mdrOut, read, yIn, zIn, zHighOut, zLowOut, incPc;
    datapathPkg::dataWord mdataIn;
    datapathPkg::dataWord busData;
    datapathPkg::dataWord marData;

    // Microstep table, one entry per clock.
    string stepName [$];
    logic [21:0] stepStrobes [$];
    datapathPkg::dataWord stepMdata [$];
    int stepCheck [$];
    datapathPkg::dataWord stepExpected [$];

    // Reference model of the register contents.
    datapathPkg::dataWord modelRegs [numRegisters];
    datapathPkg::dataWord modelPc;
    logic [31:0] rngState = 32'hde55_df66;

    datapath #(.numRegisters(numRegisters)) dut (.*);

    always #(clkPeriod / 2) clk = ~clk;

    function automatic datapathPkg::dataWord nextRandom();
        begin
            rngState = rngState ^ (rngState << 13);
            rngState = rngState ^ (rngState >> 17);
            rngState = rngState ^ (rngState << 5);
            return rngState;
        end
    endfunction

    function automatic datapathPkg::dataWord makeInstr(input datapathPkg::opcode op,
                                                       input int ra, input int rb, input int rc);
        datapathPkg::dataWord word;
        begin
            word = '0;
            word[datapathPkg::opcodeMsb:datapathPkg::opcodeLsb] = op;
            word[datapathPkg::raMsb -: $bits(datapathPkg::regIndex)] =
                datapathPkg::regIndex'(ra);
            word[datapathPkg::rbMsb -: $bits(datapathPkg::regIndex)] =
                datapathPkg::regIndex'(rb);
            word[datapathPkg::rcMsb -: $bits(datapathPkg::regIndex)] =
                datapathPkg::regIndex'(rc);
            return word;
        end
    endfunction

    // Expected Z for an operation with Y and the bus operand.
    function automatic datapathPkg::wideWord aluModel(input datapathPkg::opcode op,
                                                      input datapathPkg::dataWord y,
                                                      input datapathPkg::dataWord b);
        logic signed [63:0] wide;
        begin
            wide = $signed({{32{y[31]}}, y}) * $signed({{32{b[31]}}, b});
            case (op)
                datapathPkg::opAdd: return {32'd0, y + b};
                datapathPkg::opSub: return {32'd0, y - b};
                datapathPkg::opAnd: return {32'd0, y & b};
                datapathPkg::opOr:  return {32'd0, y | b};
                datapathPkg::opShl: return {32'd0, y << b[4:0]};
                datapathPkg::opShr: return {32'd0, y >> b[4:0]};
                datapathPkg::opNeg: return {32'd0, 32'd0 - b};
                datapathPkg::opNot: return {32'd0, ~b};
                datapathPkg::opMul: return wide;
                datapathPkg::opDiv: return {32'($signed(y) % $signed(b)), 32'($signed(y) / $signed(b))};
                default:            return '0;
            endcase
        end
    endfunction

    task automatic addStep(input string name, input logic [21:0] strobes,
                           input datapathPkg::dataWord mdata, input int check,
                           input datapathPkg::dataWord expected);
        begin
            stepName.push_back(name);
            stepStrobes.push_back(strobes);
            stepMdata.push_back(mdata);
            stepCheck.push_back(check);
            stepExpected.push_back(expected);
        end
    endtask

    // Instruction word goes through MDR into IR.
    task automatic loadIr(input datapathPkg::dataWord instr);
        begin
            addStep("MDR fetch", sMdrIn | sRead, instr, checkNone, '0);
            addStep("IR load", sMdrOut | sIrIn, '0, checkBus, instr);
        end
    endtask

    task automatic memToReg(input int n, input datapathPkg::dataWord value);
        begin
            loadIr(makeInstr('0, n, 0, 0));
            addStep("MDR read", sMdrIn | sRead, value, checkNone, '0);
            addStep($sformatf("R%0d load", n), sMdrOut | sGra | sRIn, '0, checkBus, value);
            modelRegs[n] = value;
        end
    endtask

    task automatic readRegister(input int n);
        begin
            loadIr(makeInstr('0, 0, n, 0));
            addStep($sformatf("R%0d readback", n), sGrb | sROut, '0, checkBus, modelRegs[n]);
        end
    endtask

    task automatic runAluCase(input string name, input datapathPkg::opcode op,
                              input int ra, input int rb, input int rc,
                              input datapathPkg::dataWord a, input datapathPkg::dataWord b,
                              input datapathPkg::wideWord expected);
        begin
            memToReg(rb, a);
            memToReg(rc, b);
            loadIr(makeInstr(op, ra, rb, rc));
            addStep({name, " Y"}, sGrb | sROut | sYIn, '0, checkBus, a);
            addStep({name, " Z"}, sGrc | sROut | sZIn, '0, checkBus, b);
            addStep({name, " result"}, sZLowOut | sGra | sRIn, '0, checkBus, expected[31:0]);
            modelRegs[ra] = expected[31:0];
            if (op == datapathPkg::opMul || op == datapathPkg::opDiv)
            begin
                addStep({name, " LO load"}, sZLowOut | sLoIn, '0, checkBus, expected[31:0]);
                addStep({name, " HI load"}, sZHighOut | sHiIn, '0, checkBus, expected[63:32]);
                addStep({name, " LO"}, sLoOut, '0, checkBus, expected[31:0]);
                addStep({name, " HI"}, sHiOut, '0, checkBus, expected[63:32]);
            end
            readRegister(ra);
        end
    endtask

    task automatic buildTable();
        datapathPkg::opcode ops [10];
        datapathPkg::dataWord a;
        datapathPkg::dataWord b;
        begin
            addStep("PC after reset", sPcOut, '0, checkBus, '0);
            addStep("HI after reset", sHiOut, '0, checkBus, '0);
            addStep("LO after reset", sLoOut, '0, checkBus, '0);
            for (int n = 0; n < numRegisters; n++)
                readRegister(n); // Model is still all zero here.

            memToReg(5, nextRandom());
            for (int n = 0; n < numRegisters; n++)
                readRegister(n);

            // Fetch from a random PC.
            modelPc = nextRandom();
            addStep("MDR read", sMdrIn | sRead, modelPc, checkNone, '0);
            addStep("PC load", sMdrOut | sPcIn, '0, checkBus, modelPc);
            addStep("fetch PC out", sPcOut | sMarIn | sIncPc | sZIn, '0, checkBus, modelPc);
            addStep("PC increment", sZLowOut | sPcIn, '0, checkBus, modelPc + 1);
            addStep("MAR address", '0, '0, checkMar, modelPc);
            modelPc = modelPc + 1;
            addStep("PC readback", sPcOut, '0, checkBus, modelPc);
            loadIr(makeInstr(datapathPkg::opMul, 1, 2, 3));

            ops = '{datapathPkg::opAdd, datapathPkg::opSub, datapathPkg::opAnd,
                    datapathPkg::opOr, datapathPkg::opShl, datapathPkg::opShr,
                    datapathPkg::opNeg, datapathPkg::opNot, datapathPkg::opMul,
                    datapathPkg::opDiv};
            for (int k = 0; k < 10; k++)
            begin
                a = nextRandom();
                b = nextRandom();
                if (ops[k] == datapathPkg::opDiv && b == '0)
                    b = 32'd1;
                runAluCase($sformatf("op %0d", ops[k]), ops[k], 4 + k, 1, 2, a, b,
                           aluModel(ops[k], a, b));
            end
            runAluCase("mul reference", datapathPkg::opMul, 14, 3, 15,
                       32'h0002_ECC5, 32'hFFFD_CCE5, 64'hFFFF_FFF9_90FB_C839);

            // R0 reads as zero only in base address mode.
            memToReg(0, nextRandom() | 32'd1);
            loadIr(makeInstr('0, 0, 0, 0));
            addStep("R0 base address", sGra | sBaOut, '0, checkBus, '0);
            addStep("R0 register read", sGra | sROut, '0, checkBus, modelRegs[0]);
            loadIr(makeInstr('0, 5, 0, 0));
            addStep("R5 base address", sGra | sBaOut, '0, checkBus, modelRegs[5]);
        end
    endtask

    task automatic applyStrobes(input logic [21:0] strobes);
        begin
            {incPc, zLowOut, zHighOut, zIn, yIn, read, mdrOut, mdrIn, marIn, loOut, loIn,
             hiOut, hiIn, irIn, pcOut, pcIn, baOut, rOut, rIn, grc, grb, gra} = strobes;
        end
    endtask

    task automatic waitFalling();
        bit seen;
        int tries;
        begin
            seen = 1'b0;
            tries = 0;
            while (!seen && tries < 3)
            begin
                fork
                    begin
                        @(negedge clk);
                        seen = 1'b1;
                    end
                    #(clkPeriod + clkPeriod / 2);
                join_any
                disable fork;
                tries++;
            end
            if (!seen)
            begin
                $display("Timed out waiting for a falling clock edge.");
                $display("** FAIL **");
                $fatal(1, "Clock stopped.");
            end
        end
    endtask

    task automatic checkValue(input string name, input datapathPkg::dataWord expected,
                              input datapathPkg::dataWord actual);
        begin
            assert (actual === expected)
            else
            begin
                $display("Error %s: expected %h, actual %h", name, expected, actual);
                $display("** FAIL **");
                $fatal(1, "Value mismatch.");
            end
        end
    endtask

    initial
    begin
        clk = 1'b0;
        reset = 1'b1;
        mdataIn = '0;
        applyStrobes('0);
        foreach (modelRegs[n])
            modelRegs[n] = '0;
        buildTable();
        for (int i = 0; i < 3; i++)
            waitFalling(); // Three rising edges in reset.
        reset = 1'b0;
        for (int i = 0; i < stepName.size(); i++)
        begin
            applyStrobes(stepStrobes[i]);
            mdataIn = stepMdata[i];
            waitFalling();
            if (stepCheck[i] == checkBus)
                checkValue(stepName[i], stepExpected[i], busData);
            else if (stepCheck[i] == checkMar)
                checkValue(stepName[i], stepExpected[i], marData);
        end
        applyStrobes('0);
        $display("** PASS **");
        $finish;
    end

endmodule

//--- src/datapath.sv
`timescale 1ns/1ps

module datapath #(
    parameter int numRegisters = 16
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 gra,
    input  logic                 grb,
    input  logic                 grc,
    input  logic                 rIn,
    input  logic                 rOut,
    input  logic                 baOut,
    input  logic                 pcIn,
    input  logic                 pcOut,
    input  logic                 irIn,
    input  logic                 hiIn,
    input  logic                 hiOut,
    input  logic                 loIn,
    input  logic                 loOut,
    input  logic                 marIn,
    input  logic                 mdrIn,
    input  logic                 mdrOut,
    input  logic                 read,
    input  logic                 yIn,
    input  logic                 zIn,
    input  logic                 zHighOut,
    input  logic                 zLowOut,
    input  logic                 incPc,
    input  datapathPkg::dataWord mdataIn,
    output datapathPkg::dataWord busData,
    output datapathPkg::dataWord marData
);

    datapathPkg::dataWord irData;
    datapathPkg::dataWord pcData;
    datapathPkg::dataWord hiData;
    datapathPkg::dataWord loData;
    datapathPkg::dataWord mdrData;
    datapathPkg::wideWord zData;
    datapathPkg::regIndex selNumber;
    datapathPkg::dataWord regDrives [numRegisters];
    logic regLoad;
    logic regDrive;

    registerSelect #(.numRegisters(numRegisters)) select (
        .irData(irData), .gra(gra), .grb(grb), .grc(grc),
        .rIn(rIn), .rOut(rOut), .baOut(baOut),
        .selNumber(selNumber), .regLoad(regLoad), .regDrive(regDrive)
    );

    // One slice per general register.
    for (genvar i = 0; i < numRegisters; i++)
    begin : regSlice
        generalRegister #(.regNumber(i)) slice (
            .clk(clk), .reset(reset), .busData(busData),
            .selNumber(selNumber), .regLoad(regLoad), .regDrive(regDrive),
            .drive(regDrives[i])
        );
    end

    busMux #(.numRegisters(numRegisters)) mux (
        .regDrives(regDrives), .pcData(pcData), .mdrData(mdrData),
        .hiData(hiData), .loData(loData), .zData(zData),
        .pcOut(pcOut), .mdrOut(mdrOut), .hiOut(hiOut), .loOut(loOut),
        .zHighOut(zHighOut), .zLowOut(zLowOut), .busData(busData)
    );

    specialRegisters special (
        .clk(clk), .reset(reset), .busData(busData), .mdataIn(mdataIn),
        .pcIn(pcIn), .irIn(irIn), .hiIn(hiIn), .loIn(loIn),
        .marIn(marIn), .mdrIn(mdrIn), .read(read),
        .pcData(pcData), .irData(irData), .hiData(hiData), .loData(loData),
        .mdrData(mdrData), .marData(marData)
    );

    alu aluUnit (
        .clk(clk), .reset(reset), .busData(busData), .irData(irData),
        .yIn(yIn), .zIn(zIn), .incPc(incPc), .zData(zData)
    );

endmodule

//--- src/alu.sv
`timescale 1ns/1ps

module alu (
    input  logic                 clk,
    input  logic                 reset,
    input  datapathPkg::dataWord busData,
    input  datapathPkg::dataWord irData,
    input  logic                 yIn,
    input  logic                 zIn,
    input  logic                 incPc,
    output datapathPkg::wideWord zData
);

    datapathPkg::dataWord yReg;
    datapathPkg::opcode op;
    datapathPkg::wideWord result;
    logic signed [63:0] product;
    logic signed [31:0] quotient;
    logic signed [31:0] remainder;
    logic [4:0] shiftAmount;

    assign op = irData[datapathPkg::opcodeMsb:datapathPkg::opcodeLsb];
    assign shiftAmount = busData[4:0];

    // Y holds the first operand.
    always_ff @(posedge clk)
    begin
        if (reset)
            yReg <= '0;
        else if (yIn)
            yReg <= busData;
    end

    assign product = $signed(yReg) * $signed(busData); // Full signed 64-bit product.

    // Divisor of zero yields zero instead of unknowns.
    always_comb
    begin
        if (busData == '0)
        begin
            quotient  = '0;
            remainder = '0;
        end
        else
        begin
            quotient  = $signed(yReg) / $signed(busData);
            remainder = $signed(yReg) % $signed(busData);
        end
    end

    always_comb
    begin
        result = '0;
        if (incPc)
            result = {32'd0, busData + 32'd1}; // PC increment ignores the opcode.
        else
        begin
            case (op)
                datapathPkg::opAdd: result = {32'd0, yReg + busData};
                datapathPkg::opSub: result = {32'd0, yReg - busData};
                datapathPkg::opAnd: result = {32'd0, yReg & busData};
                datapathPkg::opOr:  result = {32'd0, yReg | busData};
                datapathPkg::opShl: result = {32'd0, yReg << shiftAmount};
                datapathPkg::opShr: result = {32'd0, yReg >> shiftAmount}; // Logical.
                datapathPkg::opNeg: result = {32'd0, -busData};
                datapathPkg::opNot: result = {32'd0, ~busData};
                datapathPkg::opMul: result = product;
                datapathPkg::opDiv: result = {remainder, quotient};
                default:            result = '0;
            endcase
        end
    end

    // Z captures the result at the edge where zIn is sampled.
    always_ff @(posedge clk)
    begin
        if (reset)
            zData <= '0;
        else if (zIn)
            zData <= result;
    end

    // The controller must not divide by zero.
    assert property (@(posedge clk) disable iff (reset)
        zIn && !incPc && op == datapathPkg::opDiv |-> busData != '0)
        else $error("Division by zero latched into Z.");

endmodule

//--- src/specialRegisters.sv
`timescale 1ns/1ps

module specialRegisters (
    input  logic                 clk,
    input  logic                 reset,
    input  datapathPkg::dataWord busData,
    input  datapathPkg::dataWord mdataIn,
    input  logic                 pcIn,
    input  logic                 irIn,
    input  logic                 hiIn,
    input  logic                 loIn,
    input  logic                 marIn,
    input  logic                 mdrIn,
    input  logic                 read,
    output datapathPkg::dataWord pcData,
    output datapathPkg::dataWord irData,
    output datapathPkg::dataWord hiData,
    output datapathPkg::dataWord loData,
    output datapathPkg::dataWord mdrData,
    output datapathPkg::dataWord marData
);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pcData  <= '0;
            irData  <= '0;
            hiData  <= '0;
            loData  <= '0;
            marData <= '0;
            mdrData <= '0;
        end
        else
        begin
            if (pcIn)  pcData  <= busData;
            if (irIn)  irData  <= busData;
            if (hiIn)  hiData  <= busData;
            if (loIn)  loData  <= busData;
            if (marIn) marData <= busData; // Address toward memory.
            // Memory read path or a bus write into MDR.
            if (mdrIn) mdrData <= read ? mdataIn : busData;
        end
    end

endmodule

//--- src/busMux.sv
`timescale 1ns/1ps

module busMux #(
    parameter int numRegisters = 16
) (
    input  datapathPkg::dataWord regDrives [numRegisters],
    input  datapathPkg::dataWord pcData,
    input  datapathPkg::dataWord mdrData,
    input  datapathPkg::dataWord hiData,
    input  datapathPkg::dataWord loData,
    input  datapathPkg::wideWord zData,
    input  logic                 pcOut,
    input  logic                 mdrOut,
    input  logic                 hiOut,
    input  logic                 loOut,
    input  logic                 zHighOut,
    input  logic                 zLowOut,
    output datapathPkg::dataWord busData
);

    datapathPkg::dataWord regBus;
    datapathPkg::dataWord specialBus;

    // General registers already gate themselves.
    always_comb
    begin
        regBus = '0;
        for (int i = 0; i < numRegisters; i++)
            regBus = regBus | regDrives[i];
    end

    always_comb
    begin
        specialBus = '0;
        if (pcOut)    specialBus = specialBus | pcData;
        if (mdrOut)   specialBus = specialBus | mdrData;
        if (hiOut)    specialBus = specialBus | hiData;
        if (loOut)    specialBus = specialBus | loData;
        if (zHighOut) specialBus = specialBus | zData[63:32];
        if (zLowOut)  specialBus = specialBus | zData[31:0];
    end

    assign busData = regBus | specialBus; // Zero when nothing drives.

    always_comb
    begin
        assert #0 ($onehot0({pcOut, mdrOut, hiOut, loOut, zHighOut, zLowOut}))
            else $error("Bus contention between special sources.");
    end

endmodule

//--- src/generalRegister.sv
`timescale 1ns/1ps

module generalRegister #(
    parameter int regNumber = 0
) (
    input  logic                 clk,
    input  logic                 reset,
    input  datapathPkg::dataWord busData,
    input  datapathPkg::regIndex selNumber,
    input  logic                 regLoad,
    input  logic                 regDrive,
    output datapathPkg::dataWord drive
);

    datapathPkg::dataWord value;
    logic selected;

    assign selected = (selNumber == datapathPkg::regIndex'(regNumber));

    always_ff @(posedge clk)
    begin
        if (reset)
            value <= '0;
        else if (regLoad && selected)
            value <= busData; // Load from the bus.
    end

    assign drive = (regDrive && selected) ? value : '0; // Zero keeps the OR bus clean.

    // Contents only move on a load addressed to this slice.
    assert property (@(posedge clk)
        !reset && !(regLoad && selected) |=> $stable(value))
        else $error("Register %0d changed without a load.", regNumber);

endmodule

//--- src/registerSelect.sv
`timescale 1ns/1ps

module registerSelect #(
    parameter int numRegisters = 16
) (
    input  datapathPkg::dataWord irData,
    input  logic                 gra,
    input  logic                 grb,
    input  logic                 grc,
    input  logic                 rIn,
    input  logic                 rOut,
    input  logic                 baOut,
    output datapathPkg::regIndex selNumber,
    output logic                 regLoad,
    output logic                 regDrive
);

    datapathPkg::regIndex raField;
    datapathPkg::regIndex rbField;
    datapathPkg::regIndex rcField;
    logic inRange;

    assign raField = irData[datapathPkg::raMsb -: $bits(datapathPkg::regIndex)];
    assign rbField = irData[datapathPkg::rbMsb -: $bits(datapathPkg::regIndex)];
    assign rcField = irData[datapathPkg::rcMsb -: $bits(datapathPkg::regIndex)];

    // Field decode, the selected field wins.
    assign selNumber = ({4{gra}} & raField)
                     | ({4{grb}} & rbField)
                     | ({4{grc}} & rcField);

    // Fields beyond the register file select nothing.
    assign inRange = int'(selNumber) < numRegisters;

    assign regLoad = rIn & inRange;

    // Base address mode reads R0 as zero.
    assign regDrive = inRange & (rOut | (baOut & (selNumber != '0)));

    always_comb
    begin
        assert #0 ($onehot0({gra, grb, grc}))
            else $error("More than one register field selected.");
    end

endmodule

//--- src/datapathPkg.sv
package datapathPkg;

    // Bus and register word.
    typedef logic [31:0] dataWord;

    // Z register, product or remainder:quotient pair.
    typedef logic [63:0] wideWord;

    // General register number.
    typedef logic [3:0] regIndex;

    // IR operation field.
    typedef logic [4:0] opcode;

    // Instruction field positions. Register fields are regIndex wide.
    localparam int opcodeMsb = 31;
    localparam int opcodeLsb = 27;
    localparam int raMsb = 26;
    localparam int rbMsb = 22;
    localparam int rcMsb = 18;

    // ALU opcodes in the course encoding.
    localparam opcode opAdd = 5'b00011;
    localparam opcode opSub = 5'b00100;
    localparam opcode opShr = 5'b00101;
    localparam opcode opShl = 5'b00111;
    localparam opcode opAnd = 5'b01010;
    localparam opcode opOr  = 5'b01011;
    localparam opcode opMul = 5'b01111;
    localparam opcode opDiv = 5'b10000;
    localparam opcode opNeg = 5'b10001;
    localparam opcode opNot = 5'b10010;

endpackage
